// File: c16_io.f
hdl/c16_io_pkg.sv
hdl/io_bus_if.sv
hdl/io_bus_ctrl.sv
hdl/rom_bank_unit.sv
hdl/keyport_unit.sv
hdl/c16_io_top.sv
verif/c16_io_assertions.sv
verif/c16_io_tb.sv

// File: verif/c16_io_tb.sv
`timescale 1ns/100ps
`default_nettype none

module c16_io_tb;

	localparam logic [31:0] seed = 32'hb0bb;
	// Falling edges allowed for each handshake phase
	localparam int wait_limit = 20;

	logic        CLK28;
	logic        sreset;
	logic        req;
	logic        ack;
	logic [15:0] addr;
	logic        wr;
	logic [7:0]  wdata;
	logic [7:0]  rdata;
	logic        key_valid;
	logic [6:0]  key_code;
	logic [4:0]  joy0;
	logic [4:0]  joy1;
	logic [3:0]  rom_sel;

	// Model of the register state
	// 1 in the matrix means released
	logic [3:0]  m_bank;
	logic [7:0]  m_keyport;
	logic [7:0]  m_joy_sel;
	logic [63:0] m_matrix;

	// Expected response of the access in flight
	logic [7:0]  exp_rdata;
	logic [3:0]  exp_rom_sel;
	logic        ack_prev;
	int          error_count;
	int          i;
	logic [15:0] a;

	c16_io_top c16_io_top_i (
		.CLK28     (CLK28),
		.sreset    (sreset),
		.req       (req),
		.ack       (ack),
		.addr      (addr),
		.wr        (wr),
		.wdata     (wdata),
		.rdata     (rdata),
		.key_valid (key_valid),
		.key_code  (key_code),
		.joy0      (joy0),
		.joy1      (joy1),
		.rom_sel   (rom_sel)
	);

	initial begin
		CLK28 = 1'b0;
		forever begin
			#2 CLK28 = ~CLK28;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Register writes decoded by address
	task automatic apply_write(input logic [15:0] wa, input logic [7:0] wd);
		if (wa[15:4] == 12'hFDD) m_bank = wa[3:0];
		if (wa[15:4] == 12'hFD3) m_keyport = wd;
		if (wa == 16'hFF08) m_joy_sel = wd;
	endtask

	// Packed as rom_sel over rdata
	function automatic logic [11:0] expected_result(input logic [15:0] ea, input logic ew);
		logic [7:0] d;
		logic [3:0] sel;
		int r;
		int k;
		d = 8'hFF;
		if (!ew && ea[15:4] == 12'hFD3) begin
			d = m_keyport;
		end else if (!ew && ea == 16'hFF08) begin
			// Rows driven low by the keyport
			for (r = 0; r < 8; r++) begin
				if (!m_keyport[r]) d = d & m_matrix[r*8 +: 8];
			end
			// Joystick directions land reversed on bits 3..0
			for (k = 0; k < 4; k++) begin
				if (!m_joy_sel[2] && joy0[k]) d[3-k] = 1'b0;
				if (!m_joy_sel[1] && joy1[k]) d[3-k] = 1'b0;
			end
			if (!m_joy_sel[2] && joy0[4]) d[6] = 1'b0;
			if (!m_joy_sel[1] && joy1[4]) d[7] = 1'b0;
		end
		// Kernal page hides the high ROM bank
		sel = m_bank;
		if (ea[15:8] == 8'hFC) sel[3:2] = 2'b00;
		return {sel, d};
	endfunction

	//////////////////////////////
	// Checking
	//////////////////////////////

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h",
				$time, what, actual, expected);
			stop_with_failure();
		end
	endtask

	// rdata on each rising ack and rom_sel once the access is over
	always @(negedge CLK28) begin
		if (ack && !ack_prev) check_value(rdata, exp_rdata, $sformatf("rdata at %h", addr));
		if (!ack && ack_prev) check_value(rom_sel, exp_rom_sel, $sformatf("rom_sel at %h", addr));
		ack_prev = ack;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Full four-phase access with a random req hold
	task automatic bus_access(input logic [15:0] ba, input logic bw, input logic [7:0] bd);
		logic [11:0] res;
		int n;
		@(negedge CLK28);
		if (bw) apply_write(ba, bd);
		res = expected_result(ba, bw);
		exp_rom_sel = res[11:8];
		exp_rdata = res[7:0];
		addr = ba;
		wr = bw;
		wdata = bd;
		req = 1'b1;
		n = 0;
		while (!ack) begin
			@(negedge CLK28);
			n++;
			if (n > wait_limit) begin
				$display("Timeout: ack never rose for access to %h", ba);
				stop_with_failure();
			end
		end
		// Sample edge plus the strobe edge
		check_value(n, 2, "edges from req to ack");
		repeat ($urandom_range(0, 6)) begin
			@(negedge CLK28);
			check_value(ack, 1'b1, "ack held while req held");
		end
		req = 1'b0;
		n = 0;
		while (ack) begin
			@(negedge CLK28);
			n++;
			if (n > wait_limit) begin
				$display("Timeout: ack never fell for access to %h", ba);
				stop_with_failure();
			end
		end
		check_value(n, 1, "edges from req drop to ack drop");
	endtask

	// One-cycle key event
	// Release flag is the inverse of press
	task automatic send_key(input logic press, input logic [5:0] pos);
		@(negedge CLK28);
		key_valid = 1'b1;
		key_code = {~press, pos};
		m_matrix[pos] = ~press;
		@(negedge CLK28);
		key_valid = 1'b0;
	endtask

	initial begin
		void'($urandom(seed));
		sreset = 1'b1;
		req = 1'b0;
		addr = '0;
		wr = 1'b0;
		wdata = '0;
		key_valid = 1'b0;
		key_code = '0;
		joy0 = '0;
		joy1 = '0;
		m_bank = '0;
		m_keyport = 8'hFF;
		m_joy_sel = 8'hFF;
		m_matrix = '1;
		exp_rdata = 8'hFF;
		exp_rom_sel = '0;
		ack_prev = 1'b0;
		error_count = 0;
		repeat (8) @(posedge CLK28);
		@(negedge CLK28);
		sreset = 1'b0;

		// Reset values
		check_value(ack, 1'b0, "ack after reset");
		check_value(rom_sel, 4'h0, "rom_sel after reset");
		bus_access(16'hFD30, 1'b0, 8'h00);
		bus_access(16'hFF08, 1'b0, 8'h00);

		// Bank write, kernal page read and a read in a plain page
		for (i = 0; i < 16; i++) begin
			bus_access({12'hFDD, 4'($urandom)}, 1'b1, 8'($urandom));
			bus_access({8'hFC, 8'($urandom)}, 1'b0, 8'h00);
			bus_access(16'h8000 | 16'($urandom_range(0, 16'h3FFF)), 1'b0, 8'h00);
		end

		// Keyboard scan with both joysticks off
		bus_access(16'hFF08, 1'b1, 8'hFF);
		for (i = 0; i < 40; i++) begin
			repeat ($urandom_range(1, 4)) send_key(1'($urandom), 6'($urandom));
			bus_access({12'hFD3, 4'($urandom)}, 1'b1, 8'($urandom));
			bus_access(16'hFF08, 1'b0, 8'h00);
			bus_access({12'hFD3, 4'($urandom)}, 1'b0, 8'h00);
		end

		// Select bits 2..1 walk all four combinations
		for (i = 0; i < 32; i++) begin
			joy0 = 5'($urandom);
			joy1 = 5'($urandom);
			bus_access(16'hFF08, 1'b1, {5'($urandom), 2'(i), 1'($urandom)});
			bus_access(16'hFF08, 1'b0, 8'h00);
		end

		// Unmapped accesses
		// Mapped hits get moved off by bit 10
		for (i = 0; i < 24; i++) begin
			a = 16'($urandom);
			if (a[15:4] == 12'hFD3 || a[15:4] == 12'hFDD || a == 16'hFF08) a[10] = ~a[10];
			bus_access(a, 1'($urandom), 8'($urandom));
			bus_access(16'hFF08, 1'b0, 8'h00);
			bus_access({12'hFD3, 4'($urandom)}, 1'b0, 8'h00);
		end

		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/c16_io_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module c16_io_assertions (
	input logic CLK28,
	input logic sreset,
	input logic req,
	input logic ack,
	input logic strobe
);

	//////////////////////////////
	// Handshake and strobe
	//////////////////////////////

	// One strobe per accepted access
	strobe_single: assert property (@(posedge CLK28) disable iff (sreset)
		strobe |=> !strobe)
		else $error("strobe stayed high for more than one cycle");

	// Ack answers a request that was still pending
	ack_needs_req: assert property (@(posedge CLK28) disable iff (sreset)
		$rose(ack) |-> $past(req))
		else $error("ack rose without req high");

	// Access is already committed once ack is up
	no_strobe_in_ack: assert property (@(posedge CLK28) disable iff (sreset)
		!(strobe && ack))
		else $error("strobe seen while ack high");

	// Reset leaves the port quiet
	// Ack needs a full strobe cycle before it can rise again
	ack_low_after_reset: assert property (@(posedge CLK28)
		$fell(sreset) |-> (!ack && !strobe) ##1 !ack)
		else $error("ack or strobe high after reset");

endmodule

// Strobe comes from the interface side of the controller
bind io_bus_ctrl c16_io_assertions c16_io_assertions_i (
	.CLK28  (CLK28),
	.sreset (sreset),
	.req    (req),
	.ack    (ack),
	.strobe (bus.strobe)
);

`default_nettype wire

// File: hdl/c16_io_top.sv
`timescale 1ns/100ps
`default_nettype none

module c16_io_top (
	input  logic                              CLK28,
	input  logic                              sreset,
	// Bus master port
	input  logic                              req,
	output logic                              ack,
	input  logic [c16_io_pkg::addr_w-1:0]     addr,
	input  logic                              wr,
	input  logic [c16_io_pkg::data_w-1:0]     wdata,
	output logic [c16_io_pkg::data_w-1:0]     rdata,
	// Keyboard events
	input  logic                              key_valid,
	input  logic [c16_io_pkg::key_code_w-1:0] key_code,
	// Joysticks
	input  logic [c16_io_pkg::joy_w-1:0]      joy0,
	input  logic [c16_io_pkg::joy_w-1:0]      joy1,
	// ROM selects
	output logic [c16_io_pkg::rom_sel_w-1:0]  rom_sel
);

	//////////////////////////////
	// Internal bus
	//////////////////////////////

	// Latched access shared by both units
	io_bus_if bus ();

	// Read data of each source before the wired-AND
	logic [c16_io_pkg::data_w-1:0] bank_rdata;
	logic [c16_io_pkg::data_w-1:0] key_rdata;

	// Handshake and read merge
	io_bus_ctrl io_bus_ctrl_i (
		.CLK28      (CLK28),
		.sreset     (sreset),
		.req        (req),
		.ack        (ack),
		.addr       (addr),
		.wr         (wr),
		.wdata      (wdata),
		.rdata      (rdata),
		.bus        (bus.ctrl),
		.bank_rdata (bank_rdata),
		.key_rdata  (key_rdata)
	);

	//////////////////////////////
	// Decoding units
	//////////////////////////////

	// ROM banking at FDDx
	rom_bank_unit rom_bank_unit_i (
		.CLK28   (CLK28),
		.sreset  (sreset),
		.bus     (bus.unit),
		.rdata   (bank_rdata),
		.rom_sel (rom_sel)
	);

	// Keyport at FD3x and keyboard read at FF08
	keyport_unit keyport_unit_i (
		.CLK28     (CLK28),
		.sreset    (sreset),
		.bus       (bus.unit),
		.key_valid (key_valid),
		.key_code  (key_code),
		.joy0      (joy0),
		.joy1      (joy1),
		.rdata     (key_rdata)
	);

endmodule

`default_nettype wire

// File: hdl/keyport_unit.sv
`timescale 1ns/100ps
`default_nettype none

module keyport_unit (
	input  logic                              CLK28,
	input  logic                              sreset,
	io_bus_if.unit                            bus,
	// Decoded key events, one cycle each
	input  logic                              key_valid,
	input  logic [c16_io_pkg::key_code_w-1:0] key_code,
	// Joystick lines, high means active
	input  logic [c16_io_pkg::joy_w-1:0]      joy0,
	input  logic [c16_io_pkg::joy_w-1:0]      joy1,
	output logic [c16_io_pkg::data_w-1:0]     rdata
);

	// Turns active joystick lines into a low-active mask
	// Directions come out reversed so joy bit 0 lands on mask bit 3
	// Fire sits in mask bit 4
	function automatic logic [c16_io_pkg::joy_w-1:0] joy_mask(
		input logic                         sel,
		input logic [c16_io_pkg::joy_w-1:0] joy
	);
		logic [c16_io_pkg::joy_w-1:0] m;
		m = '1;
		// Select line is low active
		if (!sel) begin
			m = {~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
		end
		return m;
	endfunction

	//////////////////////////////
	// Latches
	//////////////////////////////

	// 6529 output drives the keyboard row lines
	logic [c16_io_pkg::data_w-1:0] keyport_latch;
	// Value last written to FF08, bits 2 and 1 select the joysticks
	logic [c16_io_pkg::data_w-1:0] joy_sel;

	logic keyport_hit;
	logic ted_kbd_hit;

	assign keyport_hit = (bus.addr[c16_io_pkg::addr_w-1:4] == c16_io_pkg::keyport_page);
	assign ted_kbd_hit = (bus.addr == c16_io_pkg::ted_kbd_addr);

	always_ff @(posedge CLK28) begin
		if (sreset) begin
			keyport_latch <= c16_io_pkg::keyport_rst;
			joy_sel       <= c16_io_pkg::joy_sel_rst;
		end else if (bus.strobe && bus.wr) begin
			if (keyport_hit) begin
				keyport_latch <= bus.wdata;
			end
			if (ted_kbd_hit) begin
				joy_sel <= bus.wdata;
			end
		end
	end

	//////////////////////////////
	// Keyboard matrix
	//////////////////////////////

	// One bit per key, row major, 1 means released
	logic [c16_io_pkg::kbd_rows*c16_io_pkg::kbd_cols-1:0] key_matrix;

	always_ff @(posedge CLK28) begin
		if (sreset) begin
			key_matrix <= '1;
		end else if (key_valid) begin
			// Code bits 5..0 are row times eight plus column
			// Press clears the bit, release sets it
			key_matrix[key_code[5:0]] <= key_code[6];
		end
	end

	//////////////////////////////
	// FF08 read
	//////////////////////////////

	logic [c16_io_pkg::data_w-1:0]  kbd_scan;
	logic [c16_io_pkg::joy_w-1:0]   joy0_m;
	logic [c16_io_pkg::joy_w-1:0]   joy1_m;
	logic [c16_io_pkg::data_w-1:0]  kbd_read;

	// AND of every row pulled low by the keyport
	always_comb begin
		kbd_scan = c16_io_pkg::bus_idle;
		for (int r = 0; r < c16_io_pkg::kbd_rows; r++) begin
			if (!keyport_latch[r]) begin
				kbd_scan = kbd_scan & key_matrix[r*c16_io_pkg::kbd_cols +: c16_io_pkg::kbd_cols];
			end
		end
	end

	assign joy0_m = joy_mask(joy_sel[2], joy0);
	assign joy1_m = joy_mask(joy_sel[1], joy1);

	// Directions share bits 3..0, fire buttons get bits 6 and 7
	assign kbd_read[3:0] = kbd_scan[3:0] & joy0_m[3:0] & joy1_m[3:0];
	assign kbd_read[5:4] = kbd_scan[5:4]; // no joystick line here
	assign kbd_read[6]   = kbd_scan[6] & joy0_m[4];
	assign kbd_read[7]   = kbd_scan[7] & joy1_m[4];

	// Read mux, FF for anything not ours
	always_comb begin
		rdata = c16_io_pkg::bus_idle;
		if (!bus.wr) begin
			if (keyport_hit) begin
				rdata = keyport_latch;
			end else if (ted_kbd_hit) begin
				rdata = kbd_read;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/rom_bank_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rom_bank_unit (
	input  logic                             CLK28,
	input  logic                             sreset,
	io_bus_if.unit                           bus,
	output logic [c16_io_pkg::data_w-1:0]    rdata,
	output logic [c16_io_pkg::rom_sel_w-1:0] rom_sel
);

	//////////////////////////////
	// Bank register
	//////////////////////////////

	logic [c16_io_pkg::rom_sel_w-1:0] bank;
	logic [c16_io_pkg::rom_sel_w-1:0] bank_next;

	// Write to FDDx
	logic bank_wr;

	// Page FCxx forces kernal in the high ROM
	logic kern;

	// The address picks the bank, data bus is ignored
	assign bank_wr = bus.strobe && bus.wr &&
		(bus.addr[c16_io_pkg::addr_w-1:4] == c16_io_pkg::rombank_page);

	assign kern = (bus.addr[c16_io_pkg::addr_w-1:8] == c16_io_pkg::kernal_page);

	// Value the register holds after this edge
	assign bank_next = bank_wr ? bus.addr[3:0] : bank;

	always_ff @(posedge CLK28) begin
		if (sreset) begin
			bank <= '0;
		end else begin
			bank <= bank_next;
		end
	end

	//////////////////////////////
	// ROM select
	//////////////////////////////

	// Registered from the next bank value
	// so a bank write and an address change both show one cycle after strobe
	always_ff @(posedge CLK28) begin
		if (sreset) begin
			rom_sel <= '0;
		end else begin
			// Low ROM bits pass straight
			rom_sel[1:0] <= bank_next[1:0];
			// High ROM goes to kernal in page FC
			rom_sel[3:2] <= bank_next[3:2] & {2{~kern}};
		end
	end

	// Banking register is write only
	assign rdata = c16_io_pkg::bus_idle;

endmodule

`default_nettype wire

// File: hdl/io_bus_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module io_bus_ctrl (
	input  logic                          CLK28,
	input  logic                          sreset,
	// Four-phase port of the outside master
	input  logic                          req,
	output logic                          ack,
	input  logic [c16_io_pkg::addr_w-1:0] addr,
	input  logic                          wr,
	input  logic [c16_io_pkg::data_w-1:0] wdata,
	output logic [c16_io_pkg::data_w-1:0] rdata,
	// Access towards the units
	io_bus_if.ctrl                        bus,
	// Read values of the units, FF when not selected
	input  logic [c16_io_pkg::data_w-1:0] bank_rdata,
	input  logic [c16_io_pkg::data_w-1:0] key_rdata
);

	//////////////////////////////
	// Handshake FSM
	//////////////////////////////

	// idle waits for req
	// strobe is the single cycle where units see the access
	// ack holds until the master lets go of req
	typedef enum logic [1:0] {
		st_idle,
		st_strobe,
		st_ack
	} state_t;

	state_t state;

	// New access only from idle, where ack is already low
	logic accept;

	// Wired-AND of all sources on the data bus
	logic [c16_io_pkg::data_w-1:0] merged;

	assign accept = (state == st_idle) && req;

	// Idle units give FF so they drop out of the AND
	assign merged = bank_rdata & key_rdata;

	always_ff @(posedge CLK28) begin
		if (sreset) begin
			state      <= st_idle;
			ack        <= 1'b0;
			bus.strobe <= 1'b0;
			rdata      <= c16_io_pkg::bus_idle;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						// Access gets latched below on this same edge
						bus.strobe <= 1'b1;
						state      <= st_strobe;
					end
				end
				st_strobe: begin
					bus.strobe <= 1'b0;
					// Units still show the read of the latched access here
					rdata      <= merged;
					ack        <= 1'b1;
					state      <= st_ack;
				end
				st_ack: begin
					// Master holding req keeps us here
					if (!req) begin
						ack   <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					bus.strobe <= 1'b0;
					ack        <= 1'b0;
					state      <= st_idle;
				end
			endcase
		end
	end

	//////////////////////////////
	// Access latch
	//////////////////////////////

	// Address and data stay put between accesses
	always_ff @(posedge CLK28) begin
		if (accept) begin
			bus.addr  <= addr;
			bus.wr    <= wr;
			bus.wdata <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: hdl/io_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface io_bus_if;

	// Last accepted access
	// Held until the controller takes the next one
	logic [c16_io_pkg::addr_w-1:0] addr;
	logic                          wr;
	logic [c16_io_pkg::data_w-1:0] wdata;

	// One clock per accepted access
	// Units commit writes on this
	logic                          strobe;

	// Controller side owns the access
	modport ctrl (
		output addr,
		output wr,
		output wdata,
		output strobe
	);

	// Decoding units only look
	modport unit (
		input addr,
		input wr,
		input wdata,
		input strobe
	);

endinterface

`default_nettype wire

// File: hdl/c16_io_pkg.sv
`default_nettype none

package c16_io_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////

	localparam int addr_w = 16;
	localparam int data_w = 8;

	// Undriven source on the wired-AND data bus
	localparam logic [data_w-1:0] bus_idle = 8'hFF;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	// FDD0 to FDDF selects the ROM bank, low nibble is the bank
	localparam logic [11:0] rombank_page = 12'hFDD;
	// FCxx always maps kernal
	localparam logic [7:0] kernal_page = 8'hFC;
	// 6529 keyport sits at FD30 to FD3F
	localparam logic [11:0] keyport_page = 12'hFD3;
	// TED keyboard latch register
	localparam logic [addr_w-1:0] ted_kbd_addr = 16'hFF08;

	//////////////////////////////
	// Keyboard and joystick
	//////////////////////////////

	// Bit 6 release flag, bits 5..3 row, bits 2..0 column
	localparam int key_code_w = 7;
	localparam int kbd_rows = 8;
	localparam int kbd_cols = 8;
	localparam int joy_w = 5;

	// Four ROM select lines, 3..2 high ROM and 1..0 low ROM
	localparam int rom_sel_w = 4;

	// Reset values
	localparam logic [data_w-1:0] keyport_rst = 8'hFF;
	localparam logic [data_w-1:0] joy_sel_rst = 8'hFF;

endpackage

`default_nettype wire
